/* vga_pkg.sv */
package vga_pkg;

        ////////////////////////////////////////
        // pixel and colour types
        ////////////////////////////////////////

        // one horizontal or vertical counter value
        typedef logic [9:0] coord_t;

        // 3-3-2 packed colour, same split as the dac pins
        typedef struct packed {
                logic [2:0] r;
                logic [2:0] g;
                logic [1:0] b;
        } rgb_t;

        localparam rgb_t color_black = '{r: 3'd0, g: 3'd0, b: 2'd0};
        localparam rgb_t color_white = '{r: 3'd7, g: 3'd7, b: 2'd3};

        ////////////////////////////////////////
        // screen timing and lane geometry
        ////////////////////////////////////////

        // first visible column after the back porch
        localparam coord_t h_back_porch = 10'd144;
        localparam coord_t h_visible    = 10'd640;
        localparam coord_t lane_width   = h_visible / 4;

        // arrow box sits centred in its lane
        localparam coord_t arrow_size  = 10'd80;
        localparam coord_t arrow_half  = arrow_size / 2;
        localparam coord_t lane_margin = (lane_width - arrow_size) / 2;
        localparam coord_t stem_lo     = arrow_size / 3;
        localparam coord_t stem_hi     = arrow_size - arrow_size / 3;

        // seven-segment cell
        localparam coord_t seg_thick   = 10'd5;
        localparam coord_t seg_mid     = 10'd20;
        localparam coord_t digit_w     = 10'd30;
        localparam coord_t digit_h     = 10'd45;
        localparam coord_t digit_pitch = 10'd40;

endpackage

/* game_pkg.sv */
package game_pkg;

        ////////////////////////////////////////
        // lanes
        ////////////////////////////////////////

        // lane index, also the arrow_shape parameter
        typedef logic [1:0] lane_t;

        localparam lane_t lane_down  = 2'd0;
        localparam lane_t lane_up    = 2'd1;
        localparam lane_t lane_left  = 2'd2;
        localparam lane_t lane_right = 2'd3;

        // decode value that highlights each lane, indexed by lane_t
        localparam logic [2:0] lane_code [4] = '{3'd3, 3'd2, 3'd0, 3'd1};

        // highlight colour per lane
        localparam vga_pkg::rgb_t lane_color [4] = '{
                '{r: 3'd7, g: 3'd0, b: 2'd3},
                '{r: 3'd0, g: 3'd7, b: 2'd0},
                '{r: 3'd0, g: 3'd0, b: 2'd3},
                '{r: 3'd7, g: 3'd0, b: 2'd0}
        };

        ////////////////////////////////////////
        // score
        ////////////////////////////////////////

        // per-lane counter wraps at 16, four of them sum to at most 60
        typedef logic [3:0] hit_count_t;
        typedef logic [5:0] score_t;

        ////////////////////////////////////////
        // screen layout rows
        ////////////////////////////////////////

        // separator bars frame the hit zone
        localparam vga_pkg::coord_t bar1_top   = 10'd201;
        localparam vga_pkg::coord_t bar2_top   = 10'd286;
        localparam vga_pkg::coord_t bar_height = 10'd5;

        // score band, bottom row exclusive
        localparam vga_pkg::coord_t score_top    = 10'd300;
        localparam vga_pkg::coord_t score_bottom = 10'd350;
        localparam vga_pkg::coord_t score_left   = 10'd280;

endpackage

/* hit_tracker.sv */
module hit_tracker (
        input  logic             d_arrow,
        input  logic             rst_n,
        input  logic             left_press,
        input  logic             right_press,
        input  logic             up_press,
        input  logic             down_press,
        input  logic             enter,
        output logic             play,
        output game_pkg::score_t score
);

        // buttons in lane order down, up, left, right
        logic [3:0] btn;
        logic [3:0] btn_q;
        logic [3:0] rise;
        logic       enter_q;

        game_pkg::hit_count_t cnt      [4];
        game_pkg::hit_count_t cnt_next [4];

        assign btn  = {right_press, left_press, up_press, down_press};
        assign rise = btn & ~btn_q;

        // counters wrap naturally at 16
        always_comb begin
                for (int i = 0; i < 4; i++) begin
                        cnt_next[i] = cnt[i] + game_pkg::hit_count_t'(rise[i]);
                end
        end

        ////////////////////////////////////////
        // press state
        ////////////////////////////////////////

        always_ff @(posedge d_arrow) begin
                if (!rst_n) begin
                        btn_q   <= '0;
                        enter_q <= 1'b0;
                        play    <= 1'b0;
                        score   <= '0;
                        for (int i = 0; i < 4; i++) begin
                                cnt[i] <= '0;
                        end
                end else begin
                        btn_q   <= btn;
                        enter_q <= enter;
                        if (enter && !enter_q) begin
                                play <= !play;
                        end
                        for (int i = 0; i < 4; i++) begin
                                cnt[i] <= cnt_next[i];
                        end
                        // sum of the next counts so score moves with play
                        score <= game_pkg::score_t'(cnt_next[0]) + game_pkg::score_t'(cnt_next[1])
                                + game_pkg::score_t'(cnt_next[2]) + game_pkg::score_t'(cnt_next[3]);
                end
        end

endmodule

/* arrow_shape.sv */
module arrow_shape #(
        parameter game_pkg::lane_t lane = game_pkg::lane_down
) (
        input  logic            d_arrow,
        input  logic            rst_n,
        input  vga_pkg::coord_t hc,
        input  vga_pkg::coord_t vc,
        input  vga_pkg::coord_t arrow_y,
        input  logic            visible,
        output logic            in_box,
        output logic            fill
);

        // first column of this lane's arrow box
        localparam vga_pkg::coord_t box_left = vga_pkg::h_back_porch
                + vga_pkg::lane_width * lane + vga_pkg::lane_margin;

        logic [10:0]     box_bottom;
        logic            box_hit;
        logic            shape_hit;
        vga_pkg::coord_t dx;
        vga_pkg::coord_t dy;
        vga_pkg::coord_t a;
        vga_pkg::coord_t b;

        // extra bit keeps arrow_y + size from wrapping
        assign box_bottom = {1'b0, arrow_y} + {1'b0, vga_pkg::arrow_size};
        assign box_hit = hc >= box_left && hc < box_left + vga_pkg::arrow_size
                && vc >= arrow_y && {1'b0, vc} < box_bottom;

        assign dx = hc - box_left;
        assign dy = vc - arrow_y;

        ////////////////////////////////////////
        // rotate into arrow-local axes
        ////////////////////////////////////////

        // a runs from stem end to tip, b runs across
        always_comb begin
                case (lane)
                        game_pkg::lane_down: begin
                                a = dy;
                                b = dx;
                        end
                        game_pkg::lane_up: begin
                                a = vga_pkg::arrow_size - 10'd1 - dy;
                                b = dx;
                        end
                        game_pkg::lane_left: begin
                                a = vga_pkg::arrow_size - 10'd1 - dx;
                                b = dy;
                        end
                        default: begin
                                a = dx;
                                b = dy;
                        end
                endcase
        end

        // stem in first half, triangle head narrowing in second half
        assign shape_hit = (a < vga_pkg::arrow_half)
                ? (b >= vga_pkg::stem_lo && b < vga_pkg::stem_hi)
                : (b >= a - vga_pkg::arrow_half
                   && b < vga_pkg::arrow_size + vga_pkg::arrow_half - a);

        always_ff @(posedge d_arrow) begin
                if (!rst_n) begin
                        in_box <= 1'b0;
                        fill   <= 1'b0;
                end else begin
                        in_box <= box_hit;
                        fill   <= box_hit && visible && shape_hit;
                end
        end

endmodule

/* score_digits.sv */
module score_digits (
        input  logic             d_arrow,
        input  logic             rst_n,
        input  vga_pkg::coord_t  hc,
        input  vga_pkg::coord_t  vc,
        input  game_pkg::score_t score,
        output logic             in_band,
        output logic             lit
);

        // segment bit order is g f e d c b a
        function automatic logic [6:0] seg_pattern(input logic [3:0] d);
                case (d)
                        4'd0:    seg_pattern = 7'b0111111;
                        4'd1:    seg_pattern = 7'b0000110;
                        4'd2:    seg_pattern = 7'b1011011;
                        4'd3:    seg_pattern = 7'b1001111;
                        4'd4:    seg_pattern = 7'b1100110;
                        4'd5:    seg_pattern = 7'b1101101;
                        4'd6:    seg_pattern = 7'b1111101;
                        4'd7:    seg_pattern = 7'b0000111;
                        4'd8:    seg_pattern = 7'b1111111;
                        4'd9:    seg_pattern = 7'b1101111;
                        default: seg_pattern = 7'b0000000;
                endcase
        endfunction

        logic [3:0]      tens;
        logic [3:0]      ones;
        logic [3:0]      digit;
        logic            in_rows;
        logic            in_tens;
        logic            in_ones;
        logic            upper;
        logic            lower;
        logic            left_col;
        logic            right_col;
        logic [6:0]      hits;
        vga_pkg::coord_t cx;
        vga_pkg::coord_t cy;

        assign tens = 4'(score / 6'd10);
        assign ones = 4'(score % 6'd10);

        ////////////////////////////////////////
        // cell select
        ////////////////////////////////////////

        assign in_rows = vc >= game_pkg::score_top
                && vc < game_pkg::score_top + vga_pkg::digit_h;
        assign in_tens = hc >= game_pkg::score_left
                && hc < game_pkg::score_left + vga_pkg::digit_w;
        assign in_ones = hc >= game_pkg::score_left + vga_pkg::digit_pitch
                && hc < game_pkg::score_left + vga_pkg::digit_pitch + vga_pkg::digit_w;

        assign digit = in_tens ? tens : ones;
        assign cx = hc - (in_tens ? game_pkg::score_left
                                  : game_pkg::score_left + vga_pkg::digit_pitch);
        assign cy = vc - game_pkg::score_top;

        // upper and lower verticals overlap on the middle bar
        assign upper     = cy < vga_pkg::seg_mid + vga_pkg::seg_thick;
        assign lower     = cy >= vga_pkg::seg_mid;
        assign left_col  = cx < vga_pkg::seg_thick;
        assign right_col = cx >= vga_pkg::digit_w - vga_pkg::seg_thick;

        assign hits[0] = cy < vga_pkg::seg_thick;
        assign hits[1] = right_col && upper;
        assign hits[2] = right_col && lower;
        assign hits[3] = cy >= vga_pkg::digit_h - vga_pkg::seg_thick;
        assign hits[4] = left_col && lower;
        assign hits[5] = left_col && upper;
        assign hits[6] = lower && cy < vga_pkg::seg_mid + vga_pkg::seg_thick;

        always_ff @(posedge d_arrow) begin
                if (!rst_n) begin
                        in_band <= 1'b0;
                        lit     <= 1'b0;
                end else begin
                        in_band <= vc >= game_pkg::score_top && vc < game_pkg::score_bottom;
                        lit     <= in_rows && (in_tens || in_ones)
                                && |(hits & seg_pattern(digit));
                end
        end

endmodule

/* pixel_mixer.sv */
module pixel_mixer (
        input  logic            d_arrow,
        input  logic            rst_n,
        input  vga_pkg::coord_t vc,
        input  logic [2:0]      decode,
        input  logic            play,
        input  logic [3:0]      in_box,
        input  logic [3:0]      fill,
        input  logic            in_band,
        input  logic            lit,
        output logic [2:0]      red,
        output logic [2:0]      green,
        output logic [1:0]      blue
);

        // delayed to line up with the stage-1 registers
        vga_pkg::coord_t vc_q;
        logic [2:0]      decode_q;
        logic            play_q;

        logic            on_bar;
        vga_pkg::rgb_t   pix;
        vga_pkg::rgb_t   pix_q;

        always_ff @(posedge d_arrow) begin
                if (!rst_n) begin
                        vc_q     <= '0;
                        decode_q <= '0;
                        play_q   <= 1'b0;
                end else begin
                        vc_q     <= vc;
                        decode_q <= decode;
                        play_q   <= play;
                end
        end

        assign on_bar = (vc_q >= game_pkg::bar1_top
                         && vc_q < game_pkg::bar1_top + game_pkg::bar_height)
                || (vc_q >= game_pkg::bar2_top
                    && vc_q < game_pkg::bar2_top + game_pkg::bar_height);

        ////////////////////////////////////////
        // colour priority
        ////////////////////////////////////////

        always_comb begin
                logic taken;
                pix   = vga_pkg::color_black;
                taken = 1'b0;
                if (!play_q) begin
                        pix = vga_pkg::color_black;
                end else if (on_bar) begin
                        pix = vga_pkg::color_white;
                end else if (in_band) begin
                        pix = lit ? vga_pkg::color_white : vga_pkg::color_black;
                end else begin
                        // lowest lane index wins where boxes overlap
                        for (int i = 0; i < 4; i++) begin
                                if (!taken && in_box[i]) begin
                                        taken = 1'b1;
                                        if (fill[i]) begin
                                                pix = (decode_q == game_pkg::lane_code[i])
                                                        ? game_pkg::lane_color[i]
                                                        : vga_pkg::color_white;
                                        end
                                end
                        end
                end
        end

        always_ff @(posedge d_arrow) begin
                if (!rst_n) begin
                        pix_q <= vga_pkg::color_black;
                end else begin
                        pix_q <= pix;
                end
        end

        assign red   = pix_q.r;
        assign green = pix_q.g;
        assign blue  = pix_q.b;

endmodule

/* dance_display_top.sv */
module dance_display_top (
        input  logic            d_arrow,
        input  logic            rst_n,
        input  logic            left_press,
        input  logic            right_press,
        input  logic            up_press,
        input  logic            down_press,
        input  logic            enter,
        input  vga_pkg::coord_t hc,
        input  vga_pkg::coord_t vc,
        input  vga_pkg::coord_t d_y,
        input  vga_pkg::coord_t u_y,
        input  vga_pkg::coord_t l_y,
        input  vga_pkg::coord_t r_y,
        input  logic            d_visible,
        input  logic            u_visible,
        input  logic            l_visible,
        input  logic            r_visible,
        input  logic [2:0]      decode,
        output logic [2:0]      red,
        output logic [2:0]      green,
        output logic [1:0]      blue
);

        logic             play;
        game_pkg::score_t score;
        logic             in_band;
        logic             lit;

        // per-lane buses in lane order down, up, left, right
        vga_pkg::coord_t  arrow_y [4];
        logic [3:0]       visible;
        logic [3:0]       in_box;
        logic [3:0]       fill;

        assign arrow_y[0] = d_y;
        assign arrow_y[1] = u_y;
        assign arrow_y[2] = l_y;
        assign arrow_y[3] = r_y;
        assign visible    = {r_visible, l_visible, u_visible, d_visible};

        hit_tracker u_hits (
                .d_arrow(d_arrow), .rst_n(rst_n),
                .left_press(left_press), .right_press(right_press),
                .up_press(up_press), .down_press(down_press), .enter(enter),
                .play(play), .score(score)
        );

        ////////////////////////////////////////
        // stage 1
        ////////////////////////////////////////

        for (genvar i = 0; i < 4; i++) begin : g_lane
                arrow_shape #(.lane(game_pkg::lane_t'(i))) u_arrow (
                        .d_arrow(d_arrow), .rst_n(rst_n), .hc(hc), .vc(vc),
                        .arrow_y(arrow_y[i]), .visible(visible[i]),
                        .in_box(in_box[i]), .fill(fill[i])
                );
        end

        score_digits u_score (
                .d_arrow(d_arrow), .rst_n(rst_n), .hc(hc), .vc(vc), .score(score),
                .in_band(in_band), .lit(lit)
        );

        // stage 2
        pixel_mixer u_mixer (
                .d_arrow(d_arrow), .rst_n(rst_n), .vc(vc), .decode(decode), .play(play),
                .in_box(in_box), .fill(fill), .in_band(in_band), .lit(lit),
                .red(red), .green(green), .blue(blue)
        );

endmodule

/* tb_dance_model.svh */
`ifndef TB_DANCE_MODEL_SVH
`define TB_DANCE_MODEL_SVH

// model registers as they stand after the last clock edge
bit       model_play;
int       model_count [4];
bit [3:0] model_btn_prev;
bit       model_enter_prev;

function automatic void reset_model();
        model_play       = 1'b0;
        model_btn_prev   = '0;
        model_enter_prev = 1'b0;
        for (int i = 0; i < 4; i++) begin
                model_count[i] = 0;
        end
endfunction

// btn in lane order down, up, left, right
function automatic void update_model(input bit [3:0] btn, input bit ent);
        if (ent && !model_enter_prev) begin
                model_play = !model_play;
        end
        for (int i = 0; i < 4; i++) begin
                if (btn[i] && !model_btn_prev[i]) begin
                        model_count[i] = (model_count[i] + 1) % 16;
                end
        end
        model_btn_prev   = btn;
        model_enter_prev = ent;
endfunction

function automatic int model_score();
        int sum;
        sum = 0;
        for (int i = 0; i < 4; i++) begin
                sum = sum + model_count[i];
        end
        return sum;
endfunction

////////////////////////////////////////
// arrow geometry
////////////////////////////////////////

function automatic int lane_box_left(input int lane);
        return 144 + 160 * lane + 40;
endfunction

function automatic bit in_arrow_box(input int lane, input int x, input int y, input int top);
        int left;
        left = lane_box_left(lane);
        return x >= left && x < left + 80 && y >= top && y < top + 80;
endfunction

// a points from the stem end towards the tip
function automatic bit arrow_filled(input int lane, input int x, input int y, input int top);
        int dx;
        int dy;
        int a;
        int b;
        dx = x - lane_box_left(lane);
        dy = y - top;
        case (lane)
                0: begin
                        a = dy;
                        b = dx;
                end
                1: begin
                        a = 79 - dy;
                        b = dx;
                end
                2: begin
                        a = 79 - dx;
                        b = dy;
                end
                default: begin
                        a = dx;
                        b = dy;
                end
        endcase
        if (a < 40) begin
                return b >= 26 && b < 54;
        end
        return b >= a - 40 && b < 120 - a;
endfunction

////////////////////////////////////////
// score glyphs
////////////////////////////////////////

// seg 0 top, 1 upper right, 2 lower right, 3 bottom, 4 lower left, 5 upper left, 6 middle
function automatic bit segment_on(input int digit, input int seg);
        case (seg)
                0:       return !(digit inside {1, 4});
                1:       return !(digit inside {5, 6});
                2:       return digit != 2;
                3:       return !(digit inside {1, 4, 7});
                4:       return digit inside {0, 2, 6, 8};
                5:       return !(digit inside {1, 2, 3, 7});
                default: return !(digit inside {0, 1, 7});
        endcase
endfunction

function automatic bit score_lit(input int score, input int x, input int y);
        int left;
        int top;
        int cx;
        int cy;
        int digit;
        bit on;
        left = game_pkg::score_left;
        top  = game_pkg::score_top;
        if (y < top || y >= top + 45) begin
                return 1'b0;
        end
        if (x >= left && x < left + 30) begin
                digit = score / 10;
                cx    = x - left;
        end else if (x >= left + 40 && x < left + 70) begin
                digit = score % 10;
                cx    = x - left - 40;
        end else begin
                return 1'b0;
        end
        cy = y - top;
        on = 1'b0;
        if (cy <= 4) on = on | segment_on(digit, 0);
        if (cy >= 20 && cy <= 24) on = on | segment_on(digit, 6);
        if (cy >= 40) on = on | segment_on(digit, 3);
        if (cx <= 4 && cy <= 24) on = on | segment_on(digit, 5);
        if (cx >= 25 && cy <= 24) on = on | segment_on(digit, 1);
        if (cx <= 4 && cy >= 20) on = on | segment_on(digit, 4);
        if (cx >= 25 && cy >= 20) on = on | segment_on(digit, 2);
        return on;
endfunction

////////////////////////////////////////
// final colour, r g b packed 3-3-2
////////////////////////////////////////

function automatic logic [7:0] expected_colour(input int x, input int y, input int rows [4],
                input bit [3:0] vis, input int code, input bit playing, input int score);
        if (!playing) begin
                return vga_pkg::color_black;
        end
        if ((y >= 201 && y <= 205) || (y >= 286 && y <= 290)) begin
                return vga_pkg::color_white;
        end
        if (y >= game_pkg::score_top && y < game_pkg::score_bottom) begin
                return score_lit(score, x, y) ? vga_pkg::color_white : vga_pkg::color_black;
        end
        // first lane in order down, up, left, right owns the pixel
        for (int i = 0; i < 4; i++) begin
                if (in_arrow_box(i, x, y, rows[i])) begin
                        if (!vis[i] || !arrow_filled(i, x, y, rows[i])) begin
                                return vga_pkg::color_black;
                        end
                        if (code == int'(game_pkg::lane_code[i])) begin
                                return game_pkg::lane_color[i];
                        end
                        return vga_pkg::color_white;
                end
        end
        return vga_pkg::color_black;
endfunction

`endif

/* tb_dance_display.sv */
module tb_dance_display;

        localparam int clk_period    = 8;
        localparam int reset_cycles  = 3;
        localparam int start_cycles  = 64;
        localparam int enter_cycles  = 160;
        localparam int press_rounds  = 3;
        localparam int presses       = 30;
        localparam int sweep_w       = 74;
        localparam int sweep_h       = 53;
        localparam int round_cycles  = presses * 6 + 4 + sweep_w * sweep_h;
        localparam int shape_cycles  = 2000;
        localparam int stream_cycles = 2000;
        localparam int total_cycles  = reset_cycles + start_cycles + enter_cycles
                + press_rounds * round_cycles + shape_cycles + stream_cycles + 2;

        logic            d_arrow;
        logic            rst_n;
        logic            left_press;
        logic            right_press;
        logic            up_press;
        logic            down_press;
        logic            enter;
        vga_pkg::coord_t hc;
        vga_pkg::coord_t vc;
        vga_pkg::coord_t d_y;
        vga_pkg::coord_t u_y;
        vga_pkg::coord_t l_y;
        vga_pkg::coord_t r_y;
        logic            d_visible;
        logic            u_visible;
        logic            l_visible;
        logic            r_visible;
        logic [2:0]      decode;
        logic [2:0]      red;
        logic [2:0]      green;
        logic [1:0]      blue;

        integer          seed;
        // [0] newest pixel, [1] the one on the outputs now
        logic [7:0]      expected [2];

        `include "tb_dance_model.svh"

        dance_display_top uut (
                .d_arrow(d_arrow), .rst_n(rst_n),
                .left_press(left_press), .right_press(right_press),
                .up_press(up_press), .down_press(down_press), .enter(enter),
                .hc(hc), .vc(vc), .d_y(d_y), .u_y(u_y), .l_y(l_y), .r_y(r_y),
                .d_visible(d_visible), .u_visible(u_visible),
                .l_visible(l_visible), .r_visible(r_visible), .decode(decode),
                .red(red), .green(green), .blue(blue)
        );

        initial begin
                d_arrow = 1'b0;
                forever #(clk_period / 2) d_arrow = ~d_arrow;
        end

        initial begin
                #(clk_period * (total_cycles + 100));
                $display("Watchdog timeout: the run took longer than all tests together");
                $display("Test failed");
                $fatal(1, "watchdog expired");
        end

        task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                        input string what);
                if (got !== want) begin
                        $display("Error at time %0t: %s is %0h, expected %0h",
                                 $time, what, got, want);
                        $display("Test failed");
                        $fatal(1, "mismatch");
                end
        endtask

        function automatic int rand_below(input int n);
                return int'($unsigned($random(seed)) % n);
        endfunction

        function automatic int lane_row(input int lane);
                case (lane)
                        0:       return d_y;
                        1:       return u_y;
                        2:       return l_y;
                        default: return r_y;
                endcase
        endfunction

        ////////////////////////////////////////
        // one clock of model and check
        ////////////////////////////////////////

        task automatic step();
                logic [7:0] colour;
                int         rows [4];
                @(posedge d_arrow);
                for (int i = 0; i < 4; i++) begin
                        rows[i] = lane_row(i);
                end
                if (!rst_n) begin
                        colour = 8'h00;
                        reset_model();
                end else begin
                        colour = expected_colour(hc, vc, rows,
                                {r_visible, l_visible, u_visible, d_visible},
                                int'(decode), model_play, model_score());
                        update_model({right_press, left_press, up_press, down_press}, enter);
                end
                expected[1] = expected[0];
                expected[0] = colour;
                @(negedge d_arrow);
                check_value(32'({red, green, blue}), 32'(expected[1]), "pixel colour");
        endtask

        task automatic set_button(input int lane, input logic level);
                case (lane)
                        0:       down_press  = level;
                        1:       up_press    = level;
                        2:       left_press  = level;
                        default: right_press = level;
                endcase
        endtask

        task automatic pulse_enter();
                enter = 1'b1;
                step();
                enter = 1'b0;
                repeat (2) step();
        endtask

        task automatic random_pixel();
                hc     = vga_pkg::coord_t'(rand_below(800));
                vc     = vga_pkg::coord_t'(rand_below(525));
                decode = 3'(rand_below(8));
        endtask

        // mostly visible arrows
        task automatic random_arrows();
                d_y    = vga_pkg::coord_t'(6 + rand_below(400));
                u_y    = vga_pkg::coord_t'(6 + rand_below(400));
                l_y    = vga_pkg::coord_t'(6 + rand_below(400));
                r_y    = vga_pkg::coord_t'(6 + rand_below(400));
                {r_visible, l_visible, u_visible, d_visible} =
                        4'(rand_below(16) | rand_below(16));
                decode = 3'(rand_below(8));
        endtask

        initial begin
                int lane;
                int hold;
                int gap;
                seed        = 32'h9d3d;
                rst_n       = 1'b0;
                left_press  = 1'b0;
                right_press = 1'b0;
                up_press    = 1'b0;
                down_press  = 1'b0;
                enter       = 1'b0;
                hc          = '0;
                vc          = '0;
                d_y         = '0;
                u_y         = '0;
                l_y         = '0;
                r_y         = '0;
                d_visible   = 1'b0;
                u_visible   = 1'b0;
                l_visible   = 1'b0;
                r_visible   = 1'b0;
                decode      = '0;
                expected[0] = 8'h00;
                expected[1] = 8'h00;
                reset_model();

                repeat (reset_cycles) step();
                rst_n = 1'b1;

                // start screen stays black
                repeat (start_cycles) begin
                        random_pixel();
                        step();
                end

                // play on, then sweep over both separator bars
                pulse_enter();
                repeat (4) step();
                check_value(32'(uut.play), 32'(model_play), "play state");
                for (int y = 195; y <= 295; y++) begin
                        hc = vga_pkg::coord_t'(144 + rand_below(640));
                        vc = vga_pkg::coord_t'(y);
                        step();
                end
                pulse_enter();
                repeat (20) begin
                        random_pixel();
                        step();
                end
                pulse_enter();

                ////////////////////////////////////////
                // button presses and score glyphs
                ////////////////////////////////////////

                for (int r = 0; r < press_rounds; r++) begin
                        for (int p = 0; p < presses; p++) begin
                                lane = rand_below(4);
                                hold = 2 + rand_below(2);
                                gap  = 2 + rand_below(2);
                                set_button(lane, 1'b1);
                                repeat (hold) step();
                                set_button(lane, 1'b0);
                                repeat (gap) step();
                        end
                        repeat (4) step();
                        check_value(32'(uut.score), 32'(model_score()), "score");
                        for (int y = 299; y < 299 + sweep_h; y++) begin
                                for (int x = 278; x < 278 + sweep_w; x++) begin
                                        hc = vga_pkg::coord_t'(x);
                                        vc = vga_pkg::coord_t'(y);
                                        step();
                                end
                        end
                end

                // pixels in and around the arrow boxes
                for (int n = 0; n < shape_cycles; n++) begin
                        if (n % 8 == 0) begin
                                random_arrows();
                        end
                        lane = rand_below(4);
                        hc   = vga_pkg::coord_t'(lane_box_left(lane) - 6 + rand_below(92));
                        vc   = vga_pkg::coord_t'(lane_row(lane) - 6 + rand_below(92));
                        step();
                end

                // back to back random pixels with stray presses
                for (int n = 0; n < stream_cycles; n++) begin
                        random_pixel();
                        if (n % 16 == 0) begin
                                random_arrows();
                        end
                        for (int i = 0; i < 4; i++) begin
                                set_button(i, rand_below(6) == 0);
                        end
                        step();
                end

                for (int i = 0; i < 4; i++) begin
                        set_button(i, 1'b0);
                end
                repeat (2) step();
                $display("Test passed");
                $finish;
        end

endmodule

/* filelist.f */
+incdir+.
vga_pkg.sv
game_pkg.sv
hit_tracker.sv
arrow_shape.sv
score_digits.sv
pixel_mixer.sv
dance_display_top.sv
tb_dance_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dance display testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_dance_display
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dance_display > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
